//--- build.f
+incdir+verif
hw/bk_pkg.sv
hw/bk_sigma_delta_dac.sv
hw/bk_audio_mix.sv
hw/bk_mouse_latch.sv
hw/bk_bus_regs.sv
hw/bk_clock_enables.sv
hw/bk_periph_top.sv
verif/tb_bk_periph.sv

//--- hw/bk_audio_mix.sv
`timescale 1ns/1ps

module bk_audio_mix import bk_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset_i,
	input  logic [2:0] spk_i,
	input  logic [7:0] psg_a_i,
	input  logic [7:0] psg_b_i,
	input  logic [7:0] psg_c_i,
	input  logic [5:0] psg_active_i,
	output logic       audio_l_o,
	output logic       audio_r_o
);

	logic [DAC_W-1:0] spk_mix;
	logic [DAC_W-1:0] code_l_d;
	logic [DAC_W-1:0] code_r_d;
	logic [DAC_W-1:0] code_l_q;
	logic [DAC_W-1:0] code_r_q;

	// Speaker is quieter when the sound chip is playing
	always_comb begin
		spk_mix = {2'b00, spk_i, 5'b00000};
		if (|psg_active_i) begin
			code_l_d = {1'b0, psg_a_i, 1'b0} + {2'b00, psg_b_i} + spk_mix;
			code_r_d = {1'b0, psg_c_i, 1'b0} + {2'b00, psg_b_i} + spk_mix;
		end else begin
			code_l_d = {spk_i, 7'b0000000};
			code_r_d = {spk_i, 7'b0000000};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			code_l_q <= '0;
			code_r_q <= '0;
		end else begin
			code_l_q <= code_l_d;
			code_r_q <= code_r_d;
		end
	end

	bk_sigma_delta_dac i_dac_l (
		.clk_sys (clk_sys),
		.reset_i (reset_i),
		.code_i  (code_l_q),
		.dac_o   (audio_l_o)
	);

	bk_sigma_delta_dac i_dac_r (
		.clk_sys (clk_sys),
		.reset_i (reset_i),
		.code_i  (code_r_q),
		.dac_o   (audio_r_o)
	);

endmodule

//--- hw/bk_bus_regs.sv
`timescale 1ns/1ps

module bk_bus_regs import bk_pkg::*; (
	input  logic             clk_sys,
	input  logic             reset_i,
	input  logic             bk0010_i,
	input  logic             bus_stb_i,
	input  logic             bus_we_i,
	input  logic             sysreg_sel_i,
	input  logic             port_sel_i,
	input  logic [1:0]       bus_wtbt_i,
	input  logic [BUS_W-1:0] bus_wdata_i,
	input  logic             key_down_i,
	input  logic             key_stop_i,
	input  logic [7:0]       joystick_i,
	input  logic             mouse_stb_i,
	input  logic [8:0]       mouse_dx_i,
	input  logic [8:0]       mouse_dy_i,
	input  logic             mouse_left_i,
	input  logic             mouse_right_i,
	output logic [BUS_W-1:0] bus_rdata_o,
	output logic             bus_rvalid_o,
	output logic             irq_stop_o,
	output logic [2:0]       spk_o
);

	logic             sysreg_acc;
	logic             sysreg_wr;
	logic             port_wr;
	logic             rd_req;
	logic             super_flg;
	logic             stop_block;
	logic             mouse_view;
	logic [BUS_W-1:0] sys_word;
	port_word_u       joy_word;
	port_word_u       mouse_word;
	port_word_u       port_word;

	assign sysreg_acc = bus_stb_i & sysreg_sel_i;
	assign sysreg_wr  = sysreg_acc & bus_we_i;
	// Only low-byte port writes reach the mouse latch
	assign port_wr    = bus_stb_i & port_sel_i & bus_we_i & bus_wtbt_i[0];
	assign rd_req     = bus_stb_i & ~bus_we_i & (sysreg_sel_i | port_sel_i);

	/////////////////////////////  System register  ////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			super_flg  <= 1'b0;
			stop_block <= 1'b0;
			spk_o      <= 3'b000;
			irq_stop_o <= 1'b0;
		end else begin
			if (sysreg_acc)
				super_flg <= bus_we_i;

			// High byte write with the lock bit set keeps the speaker bits
			if (sysreg_wr && bus_wtbt_i[0] && (!bus_wtbt_i[1] || !bus_wdata_i[SYS_BIT_LOCK])) begin
				spk_o <= {bus_wdata_i[SYS_BIT_SPK2], bus_wdata_i[SYS_BIT_SPK1],
					bus_wdata_i[SYS_BIT_SPK0] & ~bk0010_i};
			end

			if (sysreg_wr && bus_wtbt_i[1] && !bus_wdata_i[SYS_BIT_LOCK])
				stop_block <= bus_wdata_i[SYS_BIT_STOP];

			irq_stop_o <= key_stop_i & ~stop_block;
		end
	end

	//////////////////////////////  Input port  ///////////////////////////////

	// Last active device owns the port
	always_ff @(posedge clk_sys) begin
		if (reset_i)
			mouse_view <= 1'b0;
		else if (mouse_stb_i)
			mouse_view <= 1'b1;
		else if (|joystick_i)
			mouse_view <= 1'b0;
	end

	bk_mouse_latch i_mouse_latch (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.port_wr_i     (port_wr),
		.wdata_i       (bus_wdata_i),
		.mouse_stb_i   (mouse_stb_i),
		.mouse_dx_i    (mouse_dx_i),
		.mouse_dy_i    (mouse_dy_i),
		.mouse_left_i  (mouse_left_i),
		.mouse_right_i (mouse_right_i),
		.mouse_word_o  (mouse_word)
	);

	////////////////////////////////  Read mux  ////////////////////////////////

	always_comb begin
		sys_word = {START_ADDR, 1'b1, ~key_down_i, 3'b000, super_flg, 2'b00};
		joy_word = '0;
		joy_word.joy.buttons = joystick_i;
		port_word = mouse_view ? mouse_word : joy_word;
	end

	// Flag is sampled before the access updates it
	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			bus_rvalid_o <= 1'b0;
			bus_rdata_o  <= '0;
		end else begin
			bus_rvalid_o <= rd_req;
			if (rd_req)
				bus_rdata_o <= sysreg_sel_i ? sys_word : port_word;
		end
	end

endmodule

//--- hw/bk_clock_enables.sv
`timescale 1ns/1ps

module bk_clock_enables import bk_pkg::*; (
	input  logic clk_sys,
	input  logic reset_i,
	input  logic turbo_i,
	input  logic bk0010_i,
	output logic ce_cpu_p_o,
	output logic ce_cpu_n_o,
	output logic ce_psg_o
);

	logic [CPU_CNT_W-1:0] cpu_cnt;
	logic [PSG_CNT_W-1:0] psg_cnt;
	logic                 model_10_q;
	logic                 turbo_q;
	logic [CPU_CNT_W:0]   cpu_base;
	logic [CPU_CNT_W:0]   cpu_period;
	logic [CPU_CNT_W-1:0] cpu_last;
	logic [CPU_CNT_W-1:0] cpu_half;

	// Period follows the model and turbo latched at the last wrap
	always_comb begin
		cpu_base   = model_10_q ? (CPU_CNT_W+1)'(CPU_PERIOD_10) : (CPU_CNT_W+1)'(CPU_PERIOD_11);
		cpu_period = cpu_base >> turbo_q;
		cpu_last   = CPU_CNT_W'(cpu_period - 1'b1);
		cpu_half   = CPU_CNT_W'(cpu_period >> 1);
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			cpu_cnt    <= '0;
			psg_cnt    <= '0;
			model_10_q <= bk0010_i;
			turbo_q    <= turbo_i;
			ce_cpu_p_o <= 1'b0;
			ce_cpu_n_o <= 1'b0;
			ce_psg_o   <= 1'b0;
		end else begin
			if (cpu_cnt == cpu_last) begin
				cpu_cnt    <= '0;
				model_10_q <= bk0010_i;
				turbo_q    <= turbo_i;
			end else begin
				cpu_cnt <= cpu_cnt + 1'b1;
			end
			ce_cpu_p_o <= (cpu_cnt == '0);
			ce_cpu_n_o <= (cpu_cnt == cpu_half);

			if (psg_cnt == PSG_CNT_W'(PSG_PERIOD - 1))
				psg_cnt <= '0;
			else
				psg_cnt <= psg_cnt + 1'b1;
			ce_psg_o <= (psg_cnt == '0);
		end
	end

endmodule

//--- hw/bk_mouse_latch.sv
`timescale 1ns/1ps

module bk_mouse_latch import bk_pkg::*; (
	input  logic             clk_sys,
	input  logic             reset_i,
	input  logic             port_wr_i,
	input  logic [BUS_W-1:0] wdata_i,
	input  logic             mouse_stb_i,
	input  logic [8:0]       mouse_dx_i,
	input  logic [8:0]       mouse_dy_i,
	input  logic             mouse_left_i,
	input  logic             mouse_right_i,
	output port_word_u       mouse_word_o
);

	logic              mouse_en;
	logic signed [8:0] dx_s;
	logic signed [8:0] dy_s;
	logic              go_up;
	logic              go_down;
	logic              go_right;
	logic              go_left;

	// Report deltas are two's complement
	always_comb begin
		dx_s     = $signed(mouse_dx_i);
		dy_s     = $signed(mouse_dy_i);
		go_up    = dy_s > MOUSE_THRESH;
		go_down  = dy_s < -MOUSE_THRESH;
		go_right = dx_s > MOUSE_THRESH;
		go_left  = dx_s < -MOUSE_THRESH;
	end

	always_ff @(posedge clk_sys) begin
		if (reset_i) begin
			mouse_en     <= 1'b0;
			mouse_word_o <= '0;
		end else if (port_wr_i) begin
			mouse_en <= wdata_i[PORT_BIT_MOUSE_EN];
			if (!wdata_i[PORT_BIT_MOUSE_EN]) begin
				mouse_word_o.mouse.up    <= 1'b0;
				mouse_word_o.mouse.right <= 1'b0;
				mouse_word_o.mouse.down  <= 1'b0;
				mouse_word_o.mouse.left  <= 1'b0;
			end
		end else begin
			mouse_word_o.mouse.left_btn  <= mouse_left_i;
			mouse_word_o.mouse.right_btn <= mouse_right_i;
			if (mouse_en && mouse_stb_i) begin
				// One direction per axis until software clears it
				if (!mouse_word_o.mouse.up && !mouse_word_o.mouse.down) begin
					if (go_up)
						mouse_word_o.mouse.up <= 1'b1;
					if (go_down)
						mouse_word_o.mouse.down <= 1'b1;
				end
				if (!mouse_word_o.mouse.right && !mouse_word_o.mouse.left) begin
					if (go_right)
						mouse_word_o.mouse.right <= 1'b1;
					if (go_left)
						mouse_word_o.mouse.left <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/bk_periph_top.sv
`timescale 1ns/1ps

module bk_periph_top import bk_pkg::*; (
	input  logic             clk_sys,
	input  logic             reset_i,
	input  logic             turbo_i,
	input  logic             bk0010_i,
	input  logic             bus_stb_i,
	input  logic             bus_we_i,
	input  logic             sysreg_sel_i,
	input  logic             port_sel_i,
	input  logic [1:0]       bus_wtbt_i,
	input  logic [BUS_W-1:0] bus_wdata_i,
	input  logic             key_down_i,
	input  logic             key_stop_i,
	input  logic [7:0]       joystick_i,
	input  logic             mouse_stb_i,
	input  logic [8:0]       mouse_dx_i,
	input  logic [8:0]       mouse_dy_i,
	input  logic             mouse_left_i,
	input  logic             mouse_right_i,
	input  logic [7:0]       psg_a_i,
	input  logic [7:0]       psg_b_i,
	input  logic [7:0]       psg_c_i,
	input  logic [5:0]       psg_active_i,
	output logic [BUS_W-1:0] bus_rdata_o,
	output logic             bus_rvalid_o,
	output logic             irq_stop_o,
	output logic             ce_cpu_p_o,
	output logic             ce_cpu_n_o,
	output logic             ce_psg_o,
	output logic             audio_l_o,
	output logic             audio_r_o
);

	logic [2:0] spk;

	bk_clock_enables i_clock_enables (
		.clk_sys    (clk_sys),
		.reset_i    (reset_i),
		.turbo_i    (turbo_i),
		.bk0010_i   (bk0010_i),
		.ce_cpu_p_o (ce_cpu_p_o),
		.ce_cpu_n_o (ce_cpu_n_o),
		.ce_psg_o   (ce_psg_o)
	);

	bk_bus_regs i_bus_regs (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.bk0010_i      (bk0010_i),
		.bus_stb_i     (bus_stb_i),
		.bus_we_i      (bus_we_i),
		.sysreg_sel_i  (sysreg_sel_i),
		.port_sel_i    (port_sel_i),
		.bus_wtbt_i    (bus_wtbt_i),
		.bus_wdata_i   (bus_wdata_i),
		.key_down_i    (key_down_i),
		.key_stop_i    (key_stop_i),
		.joystick_i    (joystick_i),
		.mouse_stb_i   (mouse_stb_i),
		.mouse_dx_i    (mouse_dx_i),
		.mouse_dy_i    (mouse_dy_i),
		.mouse_left_i  (mouse_left_i),
		.mouse_right_i (mouse_right_i),
		.bus_rdata_o   (bus_rdata_o),
		.bus_rvalid_o  (bus_rvalid_o),
		.irq_stop_o    (irq_stop_o),
		.spk_o         (spk)
	);

	bk_audio_mix i_audio_mix (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.spk_i        (spk),
		.psg_a_i      (psg_a_i),
		.psg_b_i      (psg_b_i),
		.psg_c_i      (psg_c_i),
		.psg_active_i (psg_active_i),
		.audio_l_o    (audio_l_o),
		.audio_r_o    (audio_r_o)
	);

endmodule

//--- hw/bk_pkg.sv
package bk_pkg;

	////////////////////////////  Bus and clocking  ////////////////////////////

	localparam int BUS_W = 16;

	// CPU enable periods in clk_sys cycles, halved in turbo mode
	localparam int CPU_PERIOD_11 = 24;
	localparam int CPU_PERIOD_10 = 32;
	localparam int CPU_CNT_W     = $clog2(CPU_PERIOD_10);

	// Sound chip enable
	localparam int PSG_PERIOD = 56;
	localparam int PSG_CNT_W  = $clog2(PSG_PERIOD);

	///////////////////////////  System register  //////////////////////////////

	localparam logic [7:0] START_ADDR = 8'o200;

	localparam int SYS_BIT_SPK0 = 2;
	localparam int SYS_BIT_SPK1 = 5;
	localparam int SYS_BIT_SPK2 = 6;
	localparam int SYS_BIT_LOCK = 11;
	localparam int SYS_BIT_STOP = 12;

	/////////////////////////////  Input port  /////////////////////////////////

	localparam int PORT_BIT_MOUSE_EN = 3;

	// Motion must exceed this before a direction latches
	localparam int MOUSE_THRESH = 3;

	localparam int DAC_W = 10;

	// Joystick view: buttons in the low byte
	typedef struct packed {
		logic [7:0] rsvd_hi;
		logic [7:0] buttons;
	} joy_view_t;

	// Mouse view: directions in bits 0..3, buttons in 5 and 6
	typedef struct packed {
		logic [8:0] rsvd_hi;
		logic       right_btn;
		logic       left_btn;
		logic       rsvd_4;
		logic       left;
		logic       down;
		logic       right;
		logic       up;
	} mouse_view_t;

	typedef union packed {
		joy_view_t   joy;
		mouse_view_t mouse;
	} port_word_u;

endpackage

//--- hw/bk_sigma_delta_dac.sv
`timescale 1ns/1ps

module bk_sigma_delta_dac import bk_pkg::*; (
	input  logic             clk_sys,
	input  logic             reset_i,
	input  logic [DAC_W-1:0] code_i,
	output logic             dac_o
);

	// Top bit holds the carry of the last addition
	logic [DAC_W:0] acc_q;

	always_ff @(posedge clk_sys) begin
		if (reset_i)
			acc_q <= '0;
		else
			acc_q <= {1'b0, acc_q[DAC_W-1:0]} + {1'b0, code_i};
	end

	// Pulse density is code / 2**DAC_W
	assign dac_o = acc_q[DAC_W];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_bk_periph -f build.f -o tb_bk_periph \
	&& ./obj_dir/tb_bk_periph > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"

grep -q "TEST FAILED" "$LOG" && { echo "Simulation reported errors"; exit 1; }
grep -q "TEST PASSED" "$LOG" || { echo "Log has no pass line"; exit 1; }
exit 0

//--- verif/tb_bk_model.svh
`ifndef TB_BK_MODEL_SVH
`define TB_BK_MODEL_SVH

// Distance between two ce_cpu_p_o pulses
function automatic int exp_cpu_period(input logic model_10, input logic turbo);
	int base;
	base = model_10 ? CPU_PERIOD_10 : CPU_PERIOD_11;
	return turbo ? base / 2 : base;
endfunction

// Start address, a fixed one, the inverted key, the supervisor flag
function automatic logic [BUS_W-1:0] exp_sys_word(input logic key_down, input logic super_flag);
	logic [BUS_W-1:0] w;
	w       = '0;
	w[15:8] = START_ADDR;
	w[7]    = 1'b1;
	w[6]    = !key_down;
	w[2]    = super_flag;
	return w;
endfunction

// BK0010 has no third speaker bit
function automatic logic [2:0] exp_spk(input logic [BUS_W-1:0] data, input logic model_10);
	logic [2:0] s;
	s[2] = data[SYS_BIT_SPK2];
	s[1] = data[SYS_BIT_SPK1];
	s[0] = data[SYS_BIT_SPK0] && !model_10;
	return s;
endfunction

// Side channel is A on the left and C on the right
function automatic int exp_dac_code(input logic active, input logic [2:0] spk,
		input logic [7:0] side, input logic [7:0] chan_b);
	if (active)
		return 2 * int'(side) + int'(chan_b) + 32 * int'(spk);
	else
		return 128 * int'(spk);
endfunction

// A direction latches only while its axis is still clear
function automatic port_word_u exp_mouse_report(input port_word_u cur, input int dx, input int dy);
	port_word_u nxt;
	nxt = cur;
	if (!cur.mouse.up && !cur.mouse.down) begin
		nxt.mouse.up   = dy > MOUSE_THRESH;
		nxt.mouse.down = dy <= -(MOUSE_THRESH + 1);
	end
	if (!cur.mouse.right && !cur.mouse.left) begin
		nxt.mouse.right = dx > MOUSE_THRESH;
		nxt.mouse.left  = dx <= -(MOUSE_THRESH + 1);
	end
	return nxt;
endfunction

function automatic logic [BUS_W-1:0] exp_port_word(input logic mouse_sel, input logic [7:0] joy,
		input port_word_u mouse);
	port_word_u w;
	w = '0;
	w.joy.buttons = joy;
	if (mouse_sel)
		w = mouse;
	return w;
endfunction

`endif

//--- verif/tb_bk_periph.sv
`timescale 1ns/1ps

module tb_bk_periph import bk_pkg::*; ();

	localparam int SYS_OPS      = 200;
	localparam int JOY_STEPS    = 8;
	localparam int MOUSE_STEPS  = 40;
	localparam int AUDIO_ROUNDS = 4;
	localparam int AUDIO_WIN    = 1024;

	// Cycle budget per test
	localparam int CLK_CYC   = 4 * 4 * CPU_PERIOD_10 + 3 * PSG_PERIOD;
	localparam int SYS_CYC   = 2 * SYS_OPS;
	localparam int STOP_CYC  = 6 * 6;
	localparam int PORT_CYC  = 5 * JOY_STEPS + 5 * MOUSE_STEPS + 16;
	localparam int AUDIO_CYC = 4 * AUDIO_ROUNDS * (AUDIO_WIN + 8);
	localparam int RUN_LIMIT = 2 * (8 + CLK_CYC + SYS_CYC + STOP_CYC + PORT_CYC + AUDIO_CYC);

	logic             clk_sys;
	logic             reset_i;
	logic             turbo_i;
	logic             bk0010_i;
	logic             bus_stb_i;
	logic             bus_we_i;
	logic             sysreg_sel_i;
	logic             port_sel_i;
	logic [1:0]       bus_wtbt_i;
	logic [BUS_W-1:0] bus_wdata_i;
	logic             key_down_i;
	logic             key_stop_i;
	logic [7:0]       joystick_i;
	logic             mouse_stb_i;
	logic [8:0]       mouse_dx_i;
	logic [8:0]       mouse_dy_i;
	logic             mouse_left_i;
	logic             mouse_right_i;
	logic [7:0]       psg_a_i;
	logic [7:0]       psg_b_i;
	logic [7:0]       psg_c_i;
	logic [5:0]       psg_active_i;
	logic [BUS_W-1:0] bus_rdata_o;
	logic             bus_rvalid_o;
	logic             irq_stop_o;
	logic             ce_cpu_p_o;
	logic             ce_cpu_n_o;
	logic             ce_psg_o;
	logic             audio_l_o;
	logic             audio_r_o;

	int cycle_cnt = 0;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int err_base = 0;

	// Model state
	logic       super_m;
	logic       stop_m;
	logic       mouse_en_m;
	logic       mouse_sel_m;
	logic [2:0] spk_m;
	port_word_u mouse_m;

	// Outstanding reads, expected word and response cycle
	logic [BUS_W-1:0] rd_exp_q[$];
	int               rd_cyc_q[$];
	logic [BUS_W-1:0] cmp_word;
	int               cmp_cyc;

	`include "tb_bk_model.svh"

	bk_periph_top i_bk_periph_top (
		.clk_sys       (clk_sys),
		.reset_i       (reset_i),
		.turbo_i       (turbo_i),
		.bk0010_i      (bk0010_i),
		.bus_stb_i     (bus_stb_i),
		.bus_we_i      (bus_we_i),
		.sysreg_sel_i  (sysreg_sel_i),
		.port_sel_i    (port_sel_i),
		.bus_wtbt_i    (bus_wtbt_i),
		.bus_wdata_i   (bus_wdata_i),
		.key_down_i    (key_down_i),
		.key_stop_i    (key_stop_i),
		.joystick_i    (joystick_i),
		.mouse_stb_i   (mouse_stb_i),
		.mouse_dx_i    (mouse_dx_i),
		.mouse_dy_i    (mouse_dy_i),
		.mouse_left_i  (mouse_left_i),
		.mouse_right_i (mouse_right_i),
		.psg_a_i       (psg_a_i),
		.psg_b_i       (psg_b_i),
		.psg_c_i       (psg_c_i),
		.psg_active_i  (psg_active_i),
		.bus_rdata_o   (bus_rdata_o),
		.bus_rvalid_o  (bus_rvalid_o),
		.irq_stop_o    (irq_stop_o),
		.ce_cpu_p_o    (ce_cpu_p_o),
		.ce_cpu_n_o    (ce_cpu_n_o),
		.ce_psg_o      (ce_psg_o),
		.audio_l_o     (audio_l_o),
		.audio_r_o     (audio_r_o)
	);

	always #10 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= RUN_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", RUN_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////  Read compare  ////////////////////////////////

	always @(negedge clk_sys) begin
		if (bus_rvalid_o) begin
			if (rd_exp_q.size() == 0) begin
				$display("t=%0t: read response arrived with no read outstanding", $time);
				err_cnt++;
			end else begin
				cmp_word = rd_exp_q.pop_front();
				cmp_cyc  = rd_cyc_q.pop_front();
				check_cnt++;
				if (cmp_cyc != cycle_cnt) begin
					$display("t=%0t: read response came %0d cycles late",
						$time, cycle_cnt - cmp_cyc);
					err_cnt++;
				end
				if (bus_rdata_o !== cmp_word) begin
					$display("[FAIL] t=%0t bus_rdata_o expected %h got %h",
						$time, cmp_word, bus_rdata_o);
					err_cnt++;
				end
			end
		end else if (rd_cyc_q.size() != 0 && rd_cyc_q[0] <= cycle_cnt) begin
			$display("t=%0t: no read response one cycle after the strobe", $time);
			cmp_word = rd_exp_q.pop_front();
			cmp_cyc  = rd_cyc_q.pop_front();
			err_cnt++;
		end
	end

	////////////////////////////  Bus and mouse  ////////////////////////////////

	// Stimulus lives 2 ns after each rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic bus_write(input logic to_sys, input logic [1:0] lanes,
			input logic [BUS_W-1:0] data);
		bus_stb_i    = 1'b1;
		bus_we_i     = 1'b1;
		sysreg_sel_i = to_sys;
		port_sel_i   = !to_sys;
		bus_wtbt_i   = lanes;
		bus_wdata_i  = data;
		if (to_sys) begin
			super_m = 1'b1;
			if (lanes[0] && (!lanes[1] || !data[SYS_BIT_LOCK]))
				spk_m = exp_spk(data, bk0010_i);
			if (lanes[1] && !data[SYS_BIT_LOCK])
				stop_m = data[SYS_BIT_STOP];
		end else if (lanes[0]) begin
			mouse_en_m = data[PORT_BIT_MOUSE_EN];
			if (!data[PORT_BIT_MOUSE_EN]) begin
				mouse_m.mouse.up    = 1'b0;
				mouse_m.mouse.right = 1'b0;
				mouse_m.mouse.down  = 1'b0;
				mouse_m.mouse.left  = 1'b0;
			end
		end
		next_cycle();
		bus_stb_i    = 1'b0;
		bus_we_i     = 1'b0;
		sysreg_sel_i = 1'b0;
		port_sel_i   = 1'b0;
	endtask

	// Flag seen by a read is the one before the access
	task automatic bus_read(input logic to_sys);
		bus_stb_i    = 1'b1;
		bus_we_i     = 1'b0;
		sysreg_sel_i = to_sys;
		port_sel_i   = !to_sys;
		bus_wtbt_i   = 2'b11;
		if (to_sys) begin
			rd_exp_q.push_back(exp_sys_word(key_down_i, super_m));
			super_m = 1'b0;
		end else begin
			rd_exp_q.push_back(exp_port_word(mouse_sel_m, joystick_i, mouse_m));
		end
		rd_cyc_q.push_back(cycle_cnt + 1);
		next_cycle();
		bus_stb_i    = 1'b0;
		sysreg_sel_i = 1'b0;
		port_sel_i   = 1'b0;
	endtask

	task automatic mouse_report(input int dx, input int dy, input logic lb, input logic rb);
		mouse_stb_i   = 1'b1;
		mouse_dx_i    = 9'(dx);
		mouse_dy_i    = 9'(dy);
		mouse_left_i  = lb;
		mouse_right_i = rb;
		mouse_sel_m   = 1'b1;
		if (mouse_en_m)
			mouse_m = exp_mouse_report(mouse_m, dx, dy);
		mouse_m.mouse.left_btn  = lb;
		mouse_m.mouse.right_btn = rb;
		next_cycle();
		mouse_stb_i = 1'b0;
	endtask

	task automatic end_test(input string name);
		test_cnt++;
		$display("%s test finished with %0d errors", name, err_cnt - err_base);
		err_base = err_cnt;
	endtask

	/////////////////////////////////  Tests  //////////////////////////////////

	task automatic test_clock_enables();
		int   combo;
		int   exp_p;
		int   gap_p;
		int   gap_n;
		logic seen;
		for (combo = 0; combo < 5; combo++) begin
			next_cycle();
			bk0010_i = (combo == 4) ? 1'b0 : combo[1];
			turbo_i  = (combo == 4) ? 1'b0 : combo[0];
			exp_p    = exp_cpu_period(bk0010_i, turbo_i);
			// Skip one old period, then measure from a new one
			repeat (2) begin
				@(negedge clk_sys);
				while (!ce_cpu_p_o)
					@(negedge clk_sys);
			end
			gap_p = 0;
			gap_n = 0;
			seen  = 1'b0;
			while (!seen) begin
				@(negedge clk_sys);
				gap_p++;
				if (ce_cpu_n_o && gap_n == 0)
					gap_n = gap_p;
				seen = (combo == 4) ? ce_psg_o : ce_cpu_p_o;
			end
			check_cnt++;
			if (combo == 4) begin
				// Last round times the sound chip enable instead
				gap_p = 0;
				seen  = 1'b0;
				while (!seen) begin
					@(negedge clk_sys);
					gap_p++;
					seen = ce_psg_o;
				end
				if (gap_p != PSG_PERIOD) begin
					$display("[FAIL] t=%0t ce_psg_o period expected %0d got %0d",
						$time, PSG_PERIOD, gap_p);
					err_cnt++;
				end
			end else begin
				if (gap_p != exp_p) begin
					$display("[FAIL] t=%0t ce_cpu_p_o period expected %0d got %0d",
						$time, exp_p, gap_p);
					err_cnt++;
				end
				if (gap_n != exp_p / 2) begin
					$display("[FAIL] t=%0t ce_cpu_n_o offset expected %0d got %0d",
						$time, exp_p / 2, gap_n);
					err_cnt++;
				end
			end
		end
		next_cycle();
		end_test("Clock enable");
	endtask

	task automatic test_sysreg();
		int i;
		int op;
		for (i = 0; i < SYS_OPS; i++) begin
			key_down_i = 1'($urandom_range(1));
			op = $urandom_range(3);
			if (op == 0)
				next_cycle();
			else if (op == 3)
				bus_write(1'b1, 2'($urandom_range(3)), 16'($urandom));
			else
				bus_read(1'b1);
		end
		bus_read(1'b1);
		idle(2);
		end_test("System register");
	endtask

	task automatic stop_step(input logic [1:0] lanes, input logic lock, input logic stop);
		logic [BUS_W-1:0] data;
		logic             exp_irq;
		data = 16'($urandom);
		data[SYS_BIT_LOCK] = lock;
		data[SYS_BIT_STOP] = stop;
		bus_write(1'b1, lanes, data);
		idle(3);
		exp_irq = key_stop_i && !stop_m;
		@(negedge clk_sys);
		check_cnt++;
		if (irq_stop_o !== exp_irq) begin
			$display("[FAIL] t=%0t irq_stop_o expected %b got %b", $time, exp_irq, irq_stop_o);
			err_cnt++;
		end
		next_cycle();
	endtask

	task automatic test_stop();
		key_stop_i = 1'b1;
		stop_step(2'b10, 1'b0, 1'b1);
		stop_step(2'b10, 1'b1, 1'b0);
		stop_step(2'b11, 1'b0, 1'b0);
		stop_step(2'b11, 1'b1, 1'b1);
		stop_step(2'b10, 1'b0, 1'b1);
		stop_step(2'b11, 1'b0, 1'b0);
		key_stop_i = 1'b0;
		end_test("STOP block");
	endtask

	task automatic test_input_port();
		int i;
		for (i = 0; i < JOY_STEPS; i++) begin
			joystick_i = 8'($urandom);
			if (joystick_i != 8'h00)
				mouse_sel_m = 1'b0;
			idle(2);
			bus_read(1'b0);
			next_cycle();
		end
		joystick_i = 8'h00;
		bus_write(1'b0, 2'b01, 16'($urandom) | 16'h0008);
		for (i = 0; i < MOUSE_STEPS; i++) begin
			// Deltas around the threshold, with an occasional port write
			if ($urandom_range(5) == 0)
				bus_write(1'b0, 2'($urandom_range(3, 1)), 16'($urandom));
			else
				mouse_report(int'($urandom_range(12)) - 6, int'($urandom_range(12)) - 6,
					1'($urandom_range(1)), 1'($urandom_range(1)));
			idle(2);
			bus_read(1'b0);
			next_cycle();
		end
		end_test("Input port");
	endtask

	task automatic test_audio();
		int round;
		int n;
		int ones_l;
		int ones_r;
		int code_l;
		int code_r;
		for (round = 0; round < 4 * AUDIO_ROUNDS; round++) begin
			bk0010_i     = round[3];
			psg_active_i = round[2] ? 6'($urandom_range(63, 1)) : 6'd0;
			psg_a_i      = 8'($urandom);
			psg_b_i      = 8'($urandom);
			psg_c_i      = 8'($urandom);
			bus_write(1'b1, 2'b01, 16'($urandom));
			code_l = exp_dac_code(round[2], spk_m, psg_a_i, psg_b_i);
			code_r = exp_dac_code(round[2], spk_m, psg_c_i, psg_b_i);
			idle(4);
			ones_l = 0;
			ones_r = 0;
			for (n = 0; n < AUDIO_WIN; n++) begin
				@(negedge clk_sys);
				if (audio_l_o)
					ones_l++;
				if (audio_r_o)
					ones_r++;
			end
			check_cnt += 2;
			if (ones_l < code_l - 1 || ones_l > code_l + 1) begin
				$display("[FAIL] t=%0t audio_l_o ones expected %0d got %0d",
					$time, code_l, ones_l);
				err_cnt++;
			end
			if (ones_r < code_r - 1 || ones_r > code_r + 1) begin
				$display("[FAIL] t=%0t audio_r_o ones expected %0d got %0d",
					$time, code_r, ones_r);
				err_cnt++;
			end
			next_cycle();
		end
		end_test("Audio");
	endtask

	initial begin
		void'($urandom(32'h5808));
		clk_sys       = 1'b0;
		reset_i       = 1'b1;
		turbo_i       = 1'b0;
		bk0010_i      = 1'b0;
		bus_stb_i     = 1'b0;
		bus_we_i      = 1'b0;
		sysreg_sel_i  = 1'b0;
		port_sel_i    = 1'b0;
		bus_wtbt_i    = 2'b00;
		bus_wdata_i   = '0;
		key_down_i    = 1'b0;
		key_stop_i    = 1'b0;
		joystick_i    = 8'h00;
		mouse_stb_i   = 1'b0;
		mouse_dx_i    = '0;
		mouse_dy_i    = '0;
		mouse_left_i  = 1'b0;
		mouse_right_i = 1'b0;
		psg_a_i       = 8'h00;
		psg_b_i       = 8'h00;
		psg_c_i       = 8'h00;
		psg_active_i  = 6'd0;
		super_m       = 1'b0;
		stop_m        = 1'b0;
		mouse_en_m    = 1'b0;
		mouse_sel_m   = 1'b0;
		spk_m         = 3'b000;
		mouse_m       = '0;

		// Reset covers four rising edges
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		check_cnt++;
		if ({ce_cpu_p_o, ce_cpu_n_o, ce_psg_o, bus_rvalid_o, irq_stop_o, audio_l_o, audio_r_o} !== 7'd0
				|| bus_rdata_o !== '0) begin
			$display("t=%0t: outputs are not idle during reset", $time);
			err_cnt++;
		end
		next_cycle();
		reset_i = 1'b0;

		test_clock_enables();
		test_sysreg();
		test_stop();
		test_input_port();
		test_audio();
		idle(4);

		if (rd_exp_q.size() != 0) begin
			$display("%0d read responses never arrived", rd_exp_q.size());
			err_cnt++;
		end
		$display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
